// File: hw/corePkg.sv
package corePkg;

    parameter int dataWidth = 32;
    parameter int regAddrWidth = 5;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluLui
    } aluOpT;

    // operand source in execute
    typedef enum logic {
        fwdReg,
        fwdWb
    } fwdSelT;

    // primary opcodes
    parameter logic [5:0] opRtype = 6'h00;
    parameter logic [5:0] opJ     = 6'h02;
    parameter logic [5:0] opBeq   = 6'h04;
    parameter logic [5:0] opBne   = 6'h05;
    parameter logic [5:0] opAddiu = 6'h09;
    parameter logic [5:0] opOri   = 6'h0d;
    parameter logic [5:0] opLui   = 6'h0f;
    parameter logic [5:0] opLw    = 6'h23;
    parameter logic [5:0] opSw    = 6'h2b;

    // R-type function field
    parameter logic [5:0] fnSll  = 6'h00;
    parameter logic [5:0] fnAddu = 6'h21;
    parameter logic [5:0] fnSubu = 6'h23;
    parameter logic [5:0] fnAnd  = 6'h24;
    parameter logic [5:0] fnOr   = 6'h25;
    parameter logic [5:0] fnXor  = 6'h26;
    parameter logic [5:0] fnSlt  = 6'h2a;

    typedef struct packed {
        logic [dataWidth-1:0] instr;
        logic [dataWidth-1:0] pcPlus4;
        logic                 valid;
    } ifIdT;

    typedef struct packed {
        logic [dataWidth-1:0]    pc;
        logic [dataWidth-1:0]    rd1;
        logic [dataWidth-1:0]    rd2;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] dst;
        logic [dataWidth-1:0]    imm;
        logic [4:0]              sa;
        aluOpT                   aluOp;
        logic                    aluImmSel;
        logic                    memRead;
        logic                    memWrite;
        logic                    regWrite;
        logic                    branchEq;
        logic                    branchNe;
        logic                    jump;
        logic [dataWidth-1:0]    jumpTarget;
    } idExT;

    typedef struct packed {
        logic [dataWidth-1:0]    result;
        logic [regAddrWidth-1:0] dst;
        logic                    regWrite;
        logic                    memToReg;
    } exWbT;

endpackage

// File: hw/pipeReg.sv
module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    stall,
    input  logic    flush,
    input  payloadT din,
    output payloadT dout
);

    // all-zero payload is a bubble in every stage
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            dout <= '0;
        end else if (!stall) begin
            dout <= din;
        end
    end

endmodule

// File: hw/fetchUnit.sv
module fetchUnit #(
    parameter logic [corePkg::dataWidth-1:0] resetPc = '0
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          stall,
    input  logic                          redirect,
    input  logic [corePkg::dataWidth-1:0] redirectPc,
    output logic [corePkg::dataWidth-1:0] imemAddr,
    output logic [corePkg::dataWidth-1:0] pcPlus4
);

    import corePkg::*;

    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] pcNext;

    assign pcPlus4 = pc + 32'd4;
    assign imemAddr = pc;

    // redirect wins over a stall
    always_comb begin
        if (redirect) begin
            pcNext = redirectPc;
        end else if (stall) begin
            pcNext = pc;
        end else begin
            pcNext = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= resetPc;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

// File: hw/instrDecoder.sv
module instrDecoder (
    input  logic [corePkg::dataWidth-1:0]    instr,
    input  logic [corePkg::dataWidth-1:0]    pcPlus4,
    output logic [corePkg::regAddrWidth-1:0] rs,
    output logic [corePkg::regAddrWidth-1:0] rt,
    output logic [corePkg::regAddrWidth-1:0] dst,
    output logic [4:0]                       sa,
    output logic [corePkg::dataWidth-1:0]    imm,
    output corePkg::aluOpT                   aluOp,
    output logic                             aluImmSel,
    output logic                             memRead,
    output logic                             memWrite,
    output logic                             regWrite,
    output logic                             branchEq,
    output logic                             branchNe,
    output logic                             jump,
    output logic [corePkg::dataWidth-1:0]    jumpTarget
);

    import corePkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       zeroExt;
    logic       useRd;
    logic       writesReg;

    assign opcode = instr[31:26];
    assign funct = instr[5:0];
    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign sa = instr[10:6];

    assign imm = zeroExt ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
    assign dst = useRd ? instr[15:11] : instr[20:16];
    assign jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00};

    // a write to r0 has no effect, so it is dropped here
    assign regWrite = writesReg && (dst != '0);

    always_comb begin
        aluOp = aluAdd;
        aluImmSel = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        writesReg = 1'b0;
        branchEq = 1'b0;
        branchNe = 1'b0;
        jump = 1'b0;
        zeroExt = 1'b0;
        useRd = 1'b0;
        case (opcode)
            opRtype: begin
                useRd = 1'b1;
                writesReg = 1'b1;
                case (funct)
                    fnAddu: aluOp = aluAdd;
                    fnSubu: aluOp = aluSub;
                    fnAnd: aluOp = aluAnd;
                    fnOr: aluOp = aluOr;
                    fnXor: aluOp = aluXor;
                    fnSlt: aluOp = aluSlt;
                    fnSll: aluOp = aluSll;
                    // unknown function acts as a bubble
                    default: writesReg = 1'b0;
                endcase
            end
            opAddiu: begin
                aluImmSel = 1'b1;
                writesReg = 1'b1;
            end
            opOri: begin
                aluOp = aluOr;
                aluImmSel = 1'b1;
                zeroExt = 1'b1;
                writesReg = 1'b1;
            end
            opLui: begin
                aluOp = aluLui;
                aluImmSel = 1'b1;
                zeroExt = 1'b1;
                writesReg = 1'b1;
            end
            opLw: begin
                aluImmSel = 1'b1;
                memRead = 1'b1;
                writesReg = 1'b1;
            end
            opSw: begin
                aluImmSel = 1'b1;
                memWrite = 1'b1;
            end
            opBeq: branchEq = 1'b1;
            opBne: branchNe = 1'b1;
            opJ: jump = 1'b1;
            default: ;
        endcase
    end

endmodule

// File: hw/regFile.sv
module regFile (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [corePkg::regAddrWidth-1:0] ra1,
    input  logic [corePkg::regAddrWidth-1:0] ra2,
    input  logic [corePkg::regAddrWidth-1:0] wa,
    input  logic                             we,
    input  logic [corePkg::dataWidth-1:0]    wd,
    output logic [corePkg::dataWidth-1:0]    rd1,
    output logic [corePkg::dataWidth-1:0]    rd2
);

    import corePkg::*;

    logic [dataWidth-1:0] regs [32];
    logic                 wrValid;

    assign wrValid = we && (wa != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrValid) begin
            regs[wa] <= wd;
        end
    end

    // r0 reads zero, same-cycle write is bypassed to decode
    assign rd1 = (ra1 == '0) ? '0 : (wrValid && ra1 == wa) ? wd : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : (wrValid && ra2 == wa) ? wd : regs[ra2];

endmodule

// File: hw/aluUnit.sv
module aluUnit (
    input  logic [corePkg::dataWidth-1:0] opA,
    input  logic [corePkg::dataWidth-1:0] opB,
    input  logic [4:0]                    sa,
    input  corePkg::aluOpT                aluOp,
    input  logic                          branchEq,
    input  logic                          branchNe,
    input  logic                          jump,
    input  logic [corePkg::dataWidth-1:0] pc,
    input  logic [corePkg::dataWidth-1:0] imm,
    input  logic [corePkg::dataWidth-1:0] jumpTarget,
    output logic [corePkg::dataWidth-1:0] result,
    output logic                          redirect,
    output logic [corePkg::dataWidth-1:0] redirectPc
);

    import corePkg::*;

    logic                 opEqual;
    logic [dataWidth-1:0] branchTarget;

    always_comb begin
        case (aluOp)
            aluAdd: result = opA + opB;
            aluSub: result = opA - opB;
            aluAnd: result = opA & opB;
            aluOr: result = opA | opB;
            aluXor: result = opA ^ opB;
            aluSlt: result = {31'b0, $signed(opA) < $signed(opB)};
            // sll shifts rt, which arrives on opB
            aluSll: result = opB << sa;
            aluLui: result = {opB[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    // branches keep rt on opB, so the compare uses both operands
    assign opEqual = (opA == opB);
    assign branchTarget = pc + 32'd4 + {imm[29:0], 2'b00};

    assign redirect = jump || (branchEq && opEqual) || (branchNe && !opEqual);
    assign redirectPc = jump ? jumpTarget : branchTarget;

endmodule

// File: hw/hazardUnit.sv
module hazardUnit (
    input  logic [corePkg::regAddrWidth-1:0] rsD,
    input  logic [corePkg::regAddrWidth-1:0] rtD,
    input  logic [corePkg::regAddrWidth-1:0] rsE,
    input  logic [corePkg::regAddrWidth-1:0] rtE,
    input  logic [corePkg::regAddrWidth-1:0] dstE,
    input  logic [corePkg::regAddrWidth-1:0] dstW,
    input  logic                             memReadE,
    input  logic                             regWriteW,
    input  logic                             redirect,
    output logic                             stall,
    output logic                             flushIfId,
    output logic                             flushIdEx,
    output corePkg::fwdSelT                  fwdA,
    output corePkg::fwdSelT                  fwdB
);

    import corePkg::*;

    logic wbLive;

    // load in execute feeding decode, data only exists in writeback
    assign stall = memReadE && (dstE != '0) && ((dstE == rsD) || (dstE == rtD));

    // taken branch or jump kills decode and fetch
    assign flushIfId = redirect;
    // bubble into execute while decode is held
    assign flushIdEx = redirect || stall;

    assign wbLive = regWriteW && (dstW != '0);

    always_comb begin
        fwdA = fwdReg;
        fwdB = fwdReg;
        if (wbLive && dstW == rsE) begin
            fwdA = fwdWb;
        end
        if (wbLive && dstW == rtE) begin
            fwdB = fwdWb;
        end
    end

endmodule

// File: hw/miniCore.sv
module miniCore #(
    parameter logic [corePkg::dataWidth-1:0] resetPc = '0
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [corePkg::dataWidth-1:0]    imemData,
    input  logic [corePkg::dataWidth-1:0]    dmemRdata,
    output logic [corePkg::dataWidth-1:0]    imemAddr,
    output logic [corePkg::dataWidth-1:0]    dmemAddr,
    output logic [corePkg::dataWidth-1:0]    dmemWdata,
    output logic                             dmemWe,
    output logic                             dmemRe,
    output logic                             wbEn,
    output logic [corePkg::regAddrWidth-1:0] wbAddr,
    output logic [corePkg::dataWidth-1:0]    wbData
);

    import corePkg::*;

    // fetch
    logic [dataWidth-1:0] pcPlus4F;
    ifIdT                 ifIdD;
    ifIdT                 ifIdQ;

    // decode
    logic [dataWidth-1:0]    instrD;
    logic [regAddrWidth-1:0] rsD;
    logic [regAddrWidth-1:0] rtD;
    logic [regAddrWidth-1:0] dstD;
    logic [4:0]              saD;
    logic [dataWidth-1:0]    immD;
    aluOpT                   aluOpD;
    logic                    aluImmSelD;
    logic                    memReadD;
    logic                    memWriteD;
    logic                    regWriteD;
    logic                    branchEqD;
    logic                    branchNeD;
    logic                    jumpD;
    logic [dataWidth-1:0]    jumpTargetD;
    logic [dataWidth-1:0]    rd1D;
    logic [dataWidth-1:0]    rd2D;
    idExT                    idExD;
    idExT                    idExQ;

    // execute
    logic [dataWidth-1:0] rsValE;
    logic [dataWidth-1:0] rtValE;
    logic [dataWidth-1:0] opBE;
    logic [dataWidth-1:0] resultE;
    logic                 redirect;
    logic [dataWidth-1:0] redirectPc;
    exWbT                 exWbD;
    exWbT                 exWbQ;

    // hazards
    logic   stall;
    logic   flushIfId;
    logic   flushIdEx;
    fwdSelT fwdA;
    fwdSelT fwdB;

    fetchUnit #(
        .resetPc(resetPc)
    ) uFetch (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .imemAddr(imemAddr),
        .pcPlus4(pcPlus4F)
    );

    assign ifIdD = '{instr: imemData, pcPlus4: pcPlus4F, valid: 1'b1};

    pipeReg #(
        .payloadT(ifIdT)
    ) uIfId (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .flush(flushIfId),
        .din(ifIdD),
        .dout(ifIdQ)
    );

    // an empty slot decodes as sll r0, which writes nothing
    assign instrD = ifIdQ.valid ? ifIdQ.instr : '0;

    instrDecoder uDecoder (
        .instr(instrD),
        .pcPlus4(ifIdQ.pcPlus4),
        .rs(rsD),
        .rt(rtD),
        .dst(dstD),
        .sa(saD),
        .imm(immD),
        .aluOp(aluOpD),
        .aluImmSel(aluImmSelD),
        .memRead(memReadD),
        .memWrite(memWriteD),
        .regWrite(regWriteD),
        .branchEq(branchEqD),
        .branchNe(branchNeD),
        .jump(jumpD),
        .jumpTarget(jumpTargetD)
    );

    regFile uRegs (
        .clk(clk),
        .rst(rst),
        .ra1(rsD),
        .ra2(rtD),
        .wa(exWbQ.dst),
        .we(exWbQ.regWrite),
        .wd(wbData),
        .rd1(rd1D),
        .rd2(rd2D)
    );

    assign idExD = '{
        pc: ifIdQ.pcPlus4 - 32'd4,
        rd1: rd1D,
        rd2: rd2D,
        rs: rsD,
        rt: rtD,
        dst: dstD,
        imm: immD,
        sa: saD,
        aluOp: aluOpD,
        aluImmSel: aluImmSelD,
        memRead: memReadD,
        memWrite: memWriteD,
        regWrite: regWriteD,
        branchEq: branchEqD,
        branchNe: branchNeD,
        jump: jumpD,
        jumpTarget: jumpTargetD
    };

    pipeReg #(
        .payloadT(idExT)
    ) uIdEx (
        .clk(clk),
        .rst(rst),
        .stall(1'b0),
        .flush(flushIdEx),
        .din(idExD),
        .dout(idExQ)
    );

    // operand muxes in front of the ALU
    assign rsValE = (fwdA == fwdWb) ? wbData : idExQ.rd1;
    assign rtValE = (fwdB == fwdWb) ? wbData : idExQ.rd2;
    assign opBE = idExQ.aluImmSel ? idExQ.imm : rtValE;

    aluUnit uAlu (
        .opA(rsValE),
        .opB(opBE),
        .sa(idExQ.sa),
        .aluOp(idExQ.aluOp),
        .branchEq(idExQ.branchEq),
        .branchNe(idExQ.branchNe),
        .jump(idExQ.jump),
        .pc(idExQ.pc),
        .imm(idExQ.imm),
        .jumpTarget(idExQ.jumpTarget),
        .result(resultE),
        .redirect(redirect),
        .redirectPc(redirectPc)
    );

    hazardUnit uHazard (
        .rsD(rsD),
        .rtD(rtD),
        .rsE(idExQ.rs),
        .rtE(idExQ.rt),
        .dstE(idExQ.dst),
        .dstW(exWbQ.dst),
        .memReadE(idExQ.memRead),
        .regWriteW(exWbQ.regWrite),
        .redirect(redirect),
        .stall(stall),
        .flushIfId(flushIfId),
        .flushIdEx(flushIdEx),
        .fwdA(fwdA),
        .fwdB(fwdB)
    );

    // data memory is addressed from execute, load data returns in writeback
    assign dmemAddr = resultE;
    assign dmemWdata = rtValE;
    assign dmemWe = idExQ.memWrite;
    assign dmemRe = idExQ.memRead;

    assign exWbD = '{
        result: resultE,
        dst: idExQ.dst,
        regWrite: idExQ.regWrite,
        memToReg: idExQ.memRead
    };

    pipeReg #(
        .payloadT(exWbT)
    ) uExWb (
        .clk(clk),
        .rst(rst),
        .stall(1'b0),
        .flush(1'b0),
        .din(exWbD),
        .dout(exWbQ)
    );

    assign wbData = exWbQ.memToReg ? dmemRdata : exWbQ.result;
    assign wbEn = exWbQ.regWrite;
    assign wbAddr = exWbQ.dst;

endmodule

// File: bench/clockGen.sv
module clockGen #(
    parameter int period = 8,
    parameter int resetCycles = 4
) (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // reset drops on a rising edge
    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: bench/coreTb.sv
module coreTb;

    timeunit 1ns;
    timeprecision 100ps;

    import corePkg::*;

    localparam int clkPeriod = 8;
    localparam int resetCycles = 4;
    localparam int maxSteps = 1000;
    localparam logic [31:0] startPc = 32'h0;

    // one expected register write or store
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] addr;
        logic [31:0] data;
    } expEntryT;

    logic        clk;
    logic        rst;
    logic [31:0] imemAddr;
    logic [31:0] imemData;
    logic [31:0] dmemAddr;
    logic [31:0] dmemWdata;
    logic [31:0] dmemRdata;
    logic        dmemWe;
    logic        dmemRe;
    logic        wbEn;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;

    logic [31:0] progMem [64];
    logic [31:0] dataMem [256];
    logic [31:0] refMem [256];
    expEntryT    expRegQ [$];
    expEntryT    expStoreQ [$];

    integer seed;
    int     progLen = 0;
    int     refSteps = 0;
    int     errorCount = 0;
    int     regChecked = 0;
    int     storeChecked = 0;

    clockGen #(
        .period(clkPeriod),
        .resetCycles(resetCycles)
    ) uClock (
        .clk(clk),
        .rst(rst)
    );

    miniCore #(
        .resetPc(startPc)
    ) DUT (
        .clk(clk),
        .rst(rst),
        .imemData(imemData),
        .dmemRdata(dmemRdata),
        .imemAddr(imemAddr),
        .dmemAddr(dmemAddr),
        .dmemWdata(dmemWdata),
        .dmemWe(dmemWe),
        .dmemRe(dmemRe),
        .wbEn(wbEn),
        .wbAddr(wbAddr),
        .wbData(wbData)
    );

    // instruction memory answers in the same cycle
    assign imemData = progMem[imemAddr[7:2]];

    // data memory with one cycle of read latency
    always @(posedge clk) begin
        if (dmemWe) begin
            dataMem[dmemAddr[9:2]] <= dmemWdata;
        end
        if (dmemRe) begin
            dmemRdata <= dataMem[dmemAddr[9:2]];
        end
    end

    function automatic logic [31:0] encodeR(
        input logic [5:0] fn,
        input logic [4:0] rs,
        input logic [4:0] rt,
        input logic [4:0] rd,
        input logic [4:0] sa
    );
        return {opRtype, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] encodeI(
        input logic [5:0]  op,
        input logic [4:0]  rs,
        input logic [4:0]  rt,
        input logic [15:0] imm
    );
        return {op, rs, rt, imm};
    endfunction

    // target given as a word index
    function automatic logic [31:0] encodeJ(input int index);
        return {opJ, 26'(index)};
    endfunction

    function automatic logic [15:0] randomImm();
        return 16'($random(seed));
    endfunction

    // word-aligned offset inside the data memory window
    function automatic logic [15:0] randomOffset();
        return {8'h00, 6'($random(seed)), 2'b00};
    endfunction

    task automatic placeInstr(input logic [31:0] instr);
        progMem[progLen] = instr;
        progLen++;
    endtask

    // architectural model without a delay slot
    function automatic int runReference();
        logic [31:0] r [32];
        logic [31:0] pc;
        logic [31:0] pcPlus4;
        logic [31:0] nextPc;
        logic [31:0] ins;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [31:0] addr;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic        wrEn;
        logic [4:0]  wrAddr;
        logic [31:0] wrData;
        int          steps;
        steps = 0;
        pc = startPc;
        for (int i = 0; i < 32; i++) begin
            r[i] = '0;
        end
        while (steps < maxSteps) begin
            ins = progMem[pc[7:2]];
            rs = ins[25:21];
            rt = ins[20:16];
            rd = ins[15:11];
            sext = {{16{ins[15]}}, ins[15:0]};
            zext = {16'h0000, ins[15:0]};
            pcPlus4 = pc + 32'd4;
            nextPc = pcPlus4;
            wrEn = 1'b0;
            wrAddr = rt;
            wrData = '0;
            // a jump to itself ends the program
            if (ins[31:26] == opJ && {pcPlus4[31:28], ins[25:0], 2'b00} == pc) begin
                break;
            end
            case (ins[31:26])
                opRtype: begin
                    wrEn = 1'b1;
                    wrAddr = rd;
                    case (ins[5:0])
                        fnAddu: wrData = r[rs] + r[rt];
                        fnSubu: wrData = r[rs] - r[rt];
                        fnAnd: wrData = r[rs] & r[rt];
                        fnOr: wrData = r[rs] | r[rt];
                        fnXor: wrData = r[rs] ^ r[rt];
                        fnSlt: wrData = ($signed(r[rs]) < $signed(r[rt])) ? 32'd1 : 32'd0;
                        fnSll: wrData = r[rt] << ins[10:6];
                        default: wrEn = 1'b0;
                    endcase
                end
                opAddiu: begin
                    wrEn = 1'b1;
                    wrData = r[rs] + sext;
                end
                opOri: begin
                    wrEn = 1'b1;
                    wrData = r[rs] | zext;
                end
                opLui: begin
                    wrEn = 1'b1;
                    wrData = {ins[15:0], 16'h0000};
                end
                opLw: begin
                    addr = r[rs] + sext;
                    wrEn = 1'b1;
                    wrData = refMem[addr[9:2]];
                end
                opSw: begin
                    addr = r[rs] + sext;
                    refMem[addr[9:2]] = r[rt];
                    expStoreQ.push_back('{pc: pc, addr: addr, data: r[rt]});
                end
                opBeq: begin
                    if (r[rs] == r[rt]) begin
                        nextPc = pcPlus4 + (sext << 2);
                    end
                end
                opBne: begin
                    if (r[rs] != r[rt]) begin
                        nextPc = pcPlus4 + (sext << 2);
                    end
                end
                opJ: nextPc = {pcPlus4[31:28], ins[25:0], 2'b00};
                default: ;
            endcase
            // r0 keeps zero and leaves no trace
            if (wrEn && wrAddr != 5'd0) begin
                r[wrAddr] = wrData;
                expRegQ.push_back('{pc: pc, addr: {27'b0, wrAddr}, data: wrData});
            end
            pc = nextPc;
            steps++;
        end
        return steps;
    endfunction

    task automatic checkValue(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (actual !== expected) begin
            errorCount++;
            $display("[FAIL] %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    task automatic finishRun();
        $display("Checked %0d register writes and %0d stores, %0d errors",
                 regChecked, storeChecked, errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin : compare
        expEntryT e;
        if (rst === 1'b0) begin
            if (wbEn) begin
                if (expRegQ.size() == 0) begin
                    errorCount++;
                    $display("Register write to r%0d with data %08h was not expected",
                             wbAddr, wbData);
                end else begin
                    e = expRegQ.pop_front();
                    checkValue($sformatf("reg write of pc %08h, address", e.pc),
                               e.addr, {27'b0, wbAddr});
                    checkValue($sformatf("reg write of pc %08h, data", e.pc), e.data, wbData);
                    regChecked++;
                end
            end
            if (dmemWe) begin
                if (expStoreQ.size() == 0) begin
                    errorCount++;
                    $display("Store to %08h with data %08h was not expected",
                             dmemAddr, dmemWdata);
                end else begin
                    e = expStoreQ.pop_front();
                    checkValue($sformatf("store of pc %08h, address", e.pc), e.addr, dmemAddr);
                    checkValue($sformatf("store of pc %08h, data", e.pc), e.data, dmemWdata);
                    storeChecked++;
                end
            end
        end
    end

    initial begin : watchdog
        wait (refSteps > 0);
        #((refSteps * 4 + 50 + resetCycles) * clkPeriod);
        errorCount++;
        $display("Watchdog expired: %0d register writes and %0d stores never appeared",
                 expRegQ.size(), expStoreQ.size());
        finishRun();
    end

    initial begin : stimulus
        logic [15:0] off1;
        logic [15:0] off2;
        logic [15:0] off3;
        logic [15:0] off4;
        logic [15:0] off5;
        seed = 32'h7e0fd1a9;
        dmemRdata = '0;
        for (int i = 0; i < 64; i++) begin
            progMem[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            dataMem[i] = $random(seed);
            refMem[i] = dataMem[i];
        end
        off1 = randomOffset();
        off2 = randomOffset();
        off3 = randomOffset();
        off4 = randomOffset();
        off5 = randomOffset();

        // immediates and dependent ALU chain
        placeInstr(encodeI(opLui, 5'd0, 5'd1, randomImm()));
        placeInstr(encodeI(opOri, 5'd1, 5'd1, randomImm()));
        placeInstr(encodeI(opAddiu, 5'd0, 5'd2, randomImm()));
        placeInstr(encodeI(opAddiu, 5'd2, 5'd3, randomImm()));
        placeInstr(encodeR(fnAddu, 5'd1, 5'd2, 5'd4, 5'd0));
        placeInstr(encodeR(fnSubu, 5'd4, 5'd3, 5'd5, 5'd0));
        placeInstr(encodeR(fnAnd, 5'd5, 5'd1, 5'd6, 5'd0));
        placeInstr(encodeR(fnOr, 5'd6, 5'd2, 5'd7, 5'd0));
        placeInstr(encodeR(fnXor, 5'd7, 5'd3, 5'd8, 5'd0));
        placeInstr(encodeR(fnSlt, 5'd8, 5'd4, 5'd9, 5'd0));
        placeInstr(encodeR(fnSlt, 5'd4, 5'd8, 5'd10, 5'd0));
        placeInstr(encodeR(fnSll, 5'd0, 5'd1, 5'd11, 5'($random(seed))));
        // r0 as destination and then as source
        placeInstr(encodeR(fnAddu, 5'd1, 5'd2, 5'd0, 5'd0));
        placeInstr(encodeR(fnAddu, 5'd0, 5'd1, 5'd12, 5'd0));
        // loads and stores with load-use pairs
        placeInstr(encodeI(opOri, 5'd0, 5'd20, 16'h0100));
        placeInstr(encodeI(opLw, 5'd20, 5'd13, off1));
        placeInstr(encodeR(fnAddu, 5'd13, 5'd1, 5'd14, 5'd0));
        placeInstr(encodeI(opSw, 5'd20, 5'd14, off2));
        placeInstr(encodeI(opLw, 5'd20, 5'd15, off2));
        placeInstr(encodeR(fnSubu, 5'd15, 5'd13, 5'd16, 5'd0));
        placeInstr(encodeI(opLw, 5'd20, 5'd17, off3));
        placeInstr(encodeI(opSw, 5'd20, 5'd17, off4));
        // taken and untaken branches
        placeInstr(encodeI(opBeq, 5'd1, 5'd1, 16'd2));
        placeInstr(encodeI(opAddiu, 5'd0, 5'd21, 16'd1));
        placeInstr(encodeI(opSw, 5'd20, 5'd21, 16'd0));
        placeInstr(encodeI(opBne, 5'd1, 5'd1, 16'd1));
        placeInstr(encodeI(opAddiu, 5'd0, 5'd22, 16'd2));
        placeInstr(encodeI(opBeq, 5'd1, 5'd2, 16'd1));
        placeInstr(encodeI(opAddiu, 5'd0, 5'd23, 16'd3));
        placeInstr(encodeI(opBne, 5'd1, 5'd2, 16'd2));
        placeInstr(encodeI(opAddiu, 5'd0, 5'd24, 16'd4));
        placeInstr(encodeI(opAddiu, 5'd0, 5'd25, 16'd5));
        // jump over two instructions that must never retire
        placeInstr(encodeJ(35));
        placeInstr(encodeI(opAddiu, 5'd0, 5'd26, 16'd6));
        placeInstr(encodeI(opSw, 5'd20, 5'd26, 16'd4));
        placeInstr(encodeR(fnAddu, 5'd16, 5'd17, 5'd27, 5'd0));
        placeInstr(encodeI(opSw, 5'd20, 5'd27, off5));
        // park on a jump to itself
        placeInstr(encodeJ(37));

        refSteps = runReference();

        wait (rst === 1'b0);
        @(negedge clk);
        checkValue("PC after reset", startPc, imemAddr);
        checkValue("strobes after reset", 32'h0, {29'b0, wbEn, dmemWe, dmemRe});

        while (expRegQ.size() != 0 || expStoreQ.size() != 0) begin
            @(negedge clk);
        end
        // catch stray writes once the program is parked
        repeat (16) @(negedge clk);
        finishRun();
    end

endmodule

// File: verilog.f
hw/corePkg.sv
hw/pipeReg.sv
hw/fetchUnit.sv
hw/instrDecoder.sv
hw/regFile.sv
hw/aluUnit.sv
hw/hazardUnit.sv
hw/miniCore.sv
bench/clockGen.sv
bench/coreTb.sv

// File: Bender.yml
package:
  name: mini_core

sources:
  # RTL, package first
  - files:
      - hw/corePkg.sv
      - hw/pipeReg.sv
      - hw/fetchUnit.sv
      - hw/instrDecoder.sv
      - hw/regFile.sv
      - hw/aluUnit.sv
      - hw/hazardUnit.sv
      - hw/miniCore.sv

  # testbench
  - target: test
    files:
      - bench/clockGen.sv
      - bench/coreTb.sv
